// ==== source/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

    localparam int PIXEL_W  = 8;   // feature-map pixel
    localparam int WEIGHT_W = 4;   // one filter tap
    localparam int TAPS     = 3;   // taps per filter row
    localparam int PSUM_W   = 16;  // wide enough for three full rows
    localparam int OUT_W    = 8;   // compressed output pixel

    typedef logic [PIXEL_W-1:0]       pixel_t;      // unsigned pixel
    typedef logic [WEIGHT_W-1:0]      weight_t;     // unsigned weight
    typedef logic [TAPS*WEIGHT_W-1:0] filter_t;     // tap 0 in low bits
    typedef logic [PSUM_W-1:0]        psum_t;       // partial sum
    typedef logic [OUT_W-1:0]         out_pixel_t;  // compressed result

    // upper bounds of the four compression ranges, exclusive
    localparam psum_t CMP_LIN_MAX = 16'd64;     // identity range
    localparam psum_t CMP_MID_MAX = 16'd4096;   // step 32
    localparam psum_t CMP_HI_MAX  = 16'd8192;   // step 128
    localparam psum_t CMP_TOP_MAX = 16'd16384;  // step 256, saturate above

endpackage : conv_pkg

`default_nettype wire

// ==== source/pe_lane_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one row of the column: pixel and weights in, forwarded pixel and psum out
interface pe_lane_if;
    import conv_pkg::*;

    pixel_t  ifmap;      // current pixel for this row
    filter_t weights;    // stationary filter row
    pixel_t  ifmap_fwd;  // oldest tap, for the neighbour column
    psum_t   psum;       // registered partial sum of this row

    modport feed (        // weight bank side
        output ifmap,
        output weights
    );

    modport pe (          // processing element side
        input  ifmap,
        input  weights,
        output ifmap_fwd,
        output psum
    );

    modport drain (       // end of the psum chain
        input  psum
    );

endinterface : pe_lane_if

`default_nettype wire

// ==== source/weight_feeder.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_feeder #(
    parameter int NUM_ROWS = 3                                  // rows in the column
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,        // sync, active low
    input  wire logic                                  load_filter,  // capture strobe
    input  wire conv_pkg::pixel_t  [NUM_ROWS-1:0]      ifmap_in,     // one pixel per row
    input  wire conv_pkg::filter_t [NUM_ROWS-1:0]      filter_in,    // one filter row per row
    output      conv_pkg::filter_t [NUM_ROWS-1:0]      filter_fwd,   // held rows, for reuse
    pe_lane_if.feed                                    lanes [NUM_ROWS]
);
    import conv_pkg::*;

    filter_t [NUM_ROWS-1:0] filter_q;                           // weight bank

    // load does not wait for en, weights stay put until the next strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            filter_q <= '0;                                     // all weights zero
        end else if (load_filter) begin
            filter_q <= filter_in;                              // grab every row at once
        end
    end

    assign filter_fwd = filter_q;                               // held copy to neighbour

    // fan the bank and the pixels out to the lanes
    for (genvar r = 0; r < NUM_ROWS; r++) begin : g_lane
        assign lanes[r].ifmap   = ifmap_in[r];                  // pixel passes straight through
        assign lanes[r].weights = filter_q[r];                  // stationary row
    end

endmodule : weight_feeder

`default_nettype wire

// ==== source/pe_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pe_unit (
    input  wire logic            clk,
    input  wire logic            rst_n,    // sync, active low
    input  wire logic            en,       // level enable, hold when low
    input  wire conv_pkg::psum_t psum_in,  // from the row below, zero for row 0
    pe_lane_if.pe                lane
);
    import conv_pkg::*;

    pixel_t  taps [TAPS];   // tap window, taps[0] newest
    weight_t w    [TAPS];   // unpacked filter row
    psum_t   dot;           // three-tap dot product
    psum_t   psum_q;        // registered partial sum

    // dot product of held taps and weights
    // widened before the multiply, 3 x 255 x 15 fits easily
    always_comb begin
        dot = '0;
        for (int i = 0; i < TAPS; i++) begin
            w[i] = lane.weights[i*WEIGHT_W +: WEIGHT_W];       // tap i slice
            dot  = dot + psum_t'(w[i]) * psum_t'(taps[i]);     // unsigned mac
        end
    end

    // window shift and accumulate share the same enable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < TAPS; i++) begin
                taps[i] <= '0;                                 // empty window
            end
            psum_q <= '0;
        end else if (en) begin
            taps[0] <= lane.ifmap;                             // newest pixel in
            for (int i = 1; i < TAPS; i++) begin
                taps[i] <= taps[i-1];                          // age by one
            end
            psum_q <= psum_in + dot;                           // uses pre-edge taps
        end
    end

    assign lane.ifmap_fwd = taps[TAPS-1];                      // oldest tap, diagonal reuse
    assign lane.psum      = psum_q;                            // on up the chain

endmodule : pe_unit

`default_nettype wire

// ==== source/psum_compressor.sv ====
`timescale 1ns/1ps
`default_nettype none

module psum_compressor (
    input  wire logic                 clk,
    input  wire logic                 rst_n,      // sync, active low
    input  wire logic                 en,         // register only when high
    pe_lane_if.drain                  lane,       // last row of the column
    output      conv_pkg::out_pixel_t pixel_out   // registered 8-bit pixel
);
    import conv_pkg::*;

    // per-range offsets, chosen so the ranges join without gaps
    localparam out_pixel_t MID_OFS = 8'd62;    // 64/32 + 62 = 64
    localparam out_pixel_t HI_OFS  = 8'd158;   // 4096/128 + 158 = 190
    localparam out_pixel_t TOP_OFS = 8'd190;   // 8192/256 + 190 = 222

    psum_t      s;          // final column sum
    out_pixel_t pixel_d;    // mapped value, next pixel_out

    assign s = lane.psum;

    always_comb begin
        if (s < CMP_LIN_MAX) begin
            pixel_d = out_pixel_t'(s);                 // 0..63 as is
        end else if (s < CMP_MID_MAX) begin
            pixel_d = out_pixel_t'(s >> 5) + MID_OFS;  // 64..189
        end else if (s < CMP_HI_MAX) begin
            pixel_d = out_pixel_t'(s >> 7) + HI_OFS;   // 190..221
        end else if (s < CMP_TOP_MAX) begin
            pixel_d = out_pixel_t'(s >> 8) + TOP_OFS;  // 222..253
        end else begin
            pixel_d = '1;                              // saturate at 255
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pixel_out <= '0;
        end else if (en) begin
            pixel_out <= pixel_d;                      // hold while en low
        end
    end

endmodule : psum_compressor

`default_nettype wire

// ==== source/conv_column.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_column #(
    parameter int NUM_ROWS = 3                                     // PEs stacked in the column
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,        // sync, active low
    input  wire logic                                 en,           // compute enable
    input  wire logic                                 load_filter,  // weight capture strobe
    input  wire conv_pkg::pixel_t  [NUM_ROWS-1:0]     ifmap_in,     // row pixels
    input  wire conv_pkg::filter_t [NUM_ROWS-1:0]     filter_in,    // row filters
    output      conv_pkg::pixel_t  [NUM_ROWS-1:0]     ifmap_fwd,    // oldest taps out
    output      conv_pkg::filter_t [NUM_ROWS-1:0]     filter_fwd,   // held filters out
    output      conv_pkg::out_pixel_t                 pixel_out     // compressed result
);
    import conv_pkg::*;

    pe_lane_if lanes [NUM_ROWS] ();                                 // one lane per row

    weight_feeder #(
        .NUM_ROWS    (NUM_ROWS)
    ) u_feeder (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_filter (load_filter),
        .ifmap_in    (ifmap_in),
        .filter_in   (filter_in),
        .filter_fwd  (filter_fwd),
        .lanes       (lanes)
    );

    // psum climbs from row 0 to row NUM_ROWS-1
    for (genvar r = 0; r < NUM_ROWS; r++) begin : g_row
        psum_t psum_in;                                             // from the row below

        if (r == 0) begin : g_head
            assign psum_in = '0;                                    // bottom of chain
        end else begin : g_link
            assign psum_in = lanes[r-1].psum;                       // previous row
        end

        pe_unit u_pe (
            .clk     (clk),
            .rst_n   (rst_n),
            .en      (en),
            .psum_in (psum_in),
            .lane    (lanes[r])
        );

        assign ifmap_fwd[r] = lanes[r].ifmap_fwd;                   // export for reuse
    end

    psum_compressor u_cmp (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .lane      (lanes[NUM_ROWS-1]),                             // top of the chain
        .pixel_out (pixel_out)
    );

endmodule : conv_column

`default_nettype wire

// ==== verif/conv_column_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_column_assertions #(
    parameter int NUM_ROWS = 3                                      // rows of the bound column
) (
    input wire logic                                 clk,
    input wire logic                                 rst_n,
    input wire logic                                 en,
    input wire logic                                 load_filter,
    input wire conv_pkg::filter_t [NUM_ROWS-1:0]     filter_in,
    input wire conv_pkg::pixel_t  [NUM_ROWS-1:0]     ifmap_fwd,
    input wire conv_pkg::filter_t [NUM_ROWS-1:0]     filter_fwd,
    input wire conv_pkg::out_pixel_t                 pixel_out
);

    int fail_count = 0;                                             // assertion failures so far

    // every output cleared one edge after reset is seen
    a_reset_zero: assert property (@(posedge clk)
        !rst_n |=> (pixel_out == '0 && ifmap_fwd == '0 && filter_fwd == '0))
        else begin
            $error("outputs not cleared by reset");
            fail_count++;
        end

    a_pixel_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !en |=> $stable(pixel_out))                                 // no update while en low
        else begin
            $error("pixel_out changed while en was low");
            fail_count++;
        end

    a_filter_load: assert property (@(posedge clk) disable iff (!rst_n)
        load_filter |=> filter_fwd == $past(filter_in))             // capture in one edge
        else begin
            $error("filter_fwd does not match the loaded filter rows");
            fail_count++;
        end

endmodule : conv_column_assertions

bind conv_column conv_column_assertions #(
    .NUM_ROWS    (NUM_ROWS)
) u_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .en          (en),
    .load_filter (load_filter),
    .filter_in   (filter_in),
    .ifmap_fwd   (ifmap_fwd),
    .filter_fwd  (filter_fwd),
    .pixel_out   (pixel_out)
);

`default_nettype wire

// ==== verif/conv_column_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_column_tb;
    import conv_pkg::*;

    localparam int ROWS = 3;                       // column height under test

    typedef pixel_t  [ROWS-1:0] pixel_row_t;       // one pixel per row
    typedef filter_t [ROWS-1:0] filter_row_t;      // one filter row per row

    logic        clk;
    logic        rst_n;
    logic        en;
    logic        load_filter;
    pixel_row_t  ifmap_in;
    filter_row_t filter_in;
    pixel_row_t  ifmap_fwd;
    filter_row_t filter_fwd;
    out_pixel_t  pixel_out;

    // reference state, mirrors the DUT registers
    filter_t    m_filter [ROWS];
    pixel_t     m_taps   [ROWS][TAPS];             // [0] newest
    int         m_psum   [ROWS];
    out_pixel_t m_pix;

    int checks;
    int errors;
    int tests;

    conv_column #(
        .NUM_ROWS    (ROWS)
    ) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .load_filter (load_filter),
        .ifmap_in    (ifmap_in),
        .filter_in   (filter_in),
        .ifmap_fwd   (ifmap_fwd),
        .filter_fwd  (filter_fwd),
        .pixel_out   (pixel_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                    // 100 ns period
    end

    // piecewise output mapping, integer division
    function automatic out_pixel_t compress_sum(input int s);
        if (s < 64) return out_pixel_t'(s);
        if (s < 4096) return out_pixel_t'(s / 32 + 62);
        if (s < 8192) return out_pixel_t'(s / 128 + 158);
        if (s < 16384) return out_pixel_t'(s / 256 + 190);
        return out_pixel_t'(255);                  // saturated
    endfunction

    function automatic pixel_row_t rand_pixels();
        pixel_row_t px;
        for (int r = 0; r < ROWS; r++) begin
            px[r] = pixel_t'($urandom);
        end
        return px;
    endfunction

    function automatic filter_row_t rand_filters();
        filter_row_t f;
        for (int r = 0; r < ROWS; r++) begin
            f[r] = filter_t'($urandom);
        end
        return f;
    endfunction

    // one rising edge of the reference, old values on the right-hand side
    task automatic update_model();
        int nxt [ROWS];
        int dot;
        if (en) begin
            for (int r = 0; r < ROWS; r++) begin
                dot = 0;
                for (int i = 0; i < TAPS; i++) begin
                    dot += int'(m_filter[r][i*4 +: 4]) * int'(m_taps[r][i]);
                end
                nxt[r] = ((r == 0) ? 0 : m_psum[r-1]) + dot;   // chain from the row below
            end
            m_pix = compress_sum(m_psum[ROWS-1]);              // last row before this edge
            for (int r = 0; r < ROWS; r++) begin
                for (int i = TAPS - 1; i > 0; i--) begin
                    m_taps[r][i] = m_taps[r][i-1];
                end
                m_taps[r][0] = ifmap_in[r];
                m_psum[r]    = nxt[r] % 65536;                 // 16-bit register
            end
        end
        if (load_filter) begin
            for (int r = 0; r < ROWS; r++) begin
                m_filter[r] = filter_in[r];                    // load ignores en
            end
        end
    endtask

    task automatic compare_pixel(input string name, input pixel_t got, input pixel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_filter(input string name, input filter_t got, input filter_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_out_pixel(input string name, input out_pixel_t got,
                                     input out_pixel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_outputs();
        for (int r = 0; r < ROWS; r++) begin
            compare_pixel($sformatf("ifmap_fwd[%0d]", r), ifmap_fwd[r], m_taps[r][TAPS-1]);
            compare_filter($sformatf("filter_fwd[%0d]", r), filter_fwd[r], m_filter[r]);
        end
        compare_out_pixel("pixel_out", pixel_out, m_pix);
    endtask

    // entered at a falling edge, leaves at the next one with outputs checked
    task automatic drive_cycle(input logic e, input logic ld, input pixel_row_t px,
                               input filter_row_t f);
        en          = e;
        load_filter = ld;
        ifmap_in    = px;
        filter_in   = f;
        @(posedge clk);
        update_model();
        @(negedge clk);                            // outputs settled here
        check_outputs();
    endtask

    task automatic report_test(input string name, input int start);
        tests++;
        $display("test %-16s %s (%0d errors)", name,
                 (errors == start) ? "passed" : "FAILED", errors - start);
    endtask

    task automatic reset_test();
        int start;
        start = errors;
        check_outputs();                           // model is all zero here
        report_test("reset", start);
    endtask

    task automatic weight_hold_test();
        int          start;
        filter_row_t loaded;
        start  = errors;
        loaded = rand_filters();
        drive_cycle(1'b0, 1'b1, rand_pixels(), loaded);
        for (int i = 0; i < 50; i++) begin
            drive_cycle(1'($urandom), 1'b0, rand_pixels(), rand_filters());
            for (int r = 0; r < ROWS; r++) begin
                compare_filter($sformatf("filter_fwd[%0d]", r), filter_fwd[r], loaded[r]);
            end
        end
        report_test("weight hold", start);
    endtask

    task automatic forwarding_test();
        int         start;
        logic       e;
        pixel_row_t px;
        pixel_row_t hist [$];                      // pixels taken on enabled edges
        start = errors;
        for (int i = 0; i < 60; i++) begin
            e  = ($urandom % 4) != 0;              // mostly enabled
            px = rand_pixels();
            drive_cycle(e, 1'b0, px, rand_filters());
            if (e) hist.push_back(px);
            if (hist.size() >= TAPS) begin
                for (int r = 0; r < ROWS; r++) begin
                    compare_pixel($sformatf("ifmap_fwd[%0d]", r), ifmap_fwd[r],
                                  hist[hist.size()-TAPS][r]);
                end
            end
        end
        report_test("pixel forwarding", start);
    endtask

    task automatic accumulation_test();
        int start;
        start = errors;
        for (int i = 0; i < 300; i++) begin
            drive_cycle(1'($urandom), ($urandom % 16) == 0, rand_pixels(), rand_filters());
        end
        report_test("accumulation", start);
    endtask

    task automatic range_test();
        int          start;
        int          wt [5];
        int          pv [5];
        pixel_row_t  prow;
        filter_row_t frow;
        start = errors;
        wt    = '{1, 2, 5, 7, 15};                 // one pair per compression range
        pv    = '{5, 100, 120, 200, 255};
        for (int k = 0; k < 5; k++) begin
            for (int r = 0; r < ROWS; r++) begin
                prow[r] = pixel_t'(pv[k]);
                frow[r] = {TAPS{weight_t'(wt[k])}};
            end
            drive_cycle(1'b1, 1'b1, prow, frow);
            repeat (10) drive_cycle(1'b1, 1'b0, prow, frow);   // fill taps and chain
            compare_out_pixel("pixel_out", pixel_out,
                              compress_sum(ROWS * TAPS * wt[k] * pv[k]));
        end
        report_test("compression", start);
    endtask

    task automatic freeze_test();
        int         start;
        pixel_row_t held_px;
        out_pixel_t held_out;
        start    = errors;
        drive_cycle(1'b1, 1'b1, rand_pixels(), rand_filters());   // fresh weights
        repeat (6) drive_cycle(1'b1, 1'b0, rand_pixels(), rand_filters());   // chain in motion
        held_px  = ifmap_fwd;
        held_out = pixel_out;
        for (int i = 0; i < 20; i++) begin
            drive_cycle(1'b0, 1'b0, rand_pixels(), rand_filters());
            for (int r = 0; r < ROWS; r++) begin
                compare_pixel($sformatf("ifmap_fwd[%0d]", r), ifmap_fwd[r], held_px[r]);
            end
            compare_out_pixel("pixel_out", pixel_out, held_out);
        end
        report_test("enable freeze", start);
    endtask

    initial begin
        int   wait_cnt;
        logic reset_cleared;
        void'($urandom(98665));                    // single seed for the run
        rst_n       = 1'b0;
        en          = 1'b0;
        load_filter = 1'b0;
        ifmap_in    = '0;
        filter_in   = '0;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        m_pix       = '0;
        for (int r = 0; r < ROWS; r++) begin
            m_filter[r] = '0;
            m_psum[r]   = 0;
            for (int i = 0; i < TAPS; i++) begin
                m_taps[r][i] = '0;
            end
        end
        repeat (3) @(posedge clk);                 // reset held three cycles
        @(negedge clk);
        rst_n    = 1'b1;
        wait_cnt = 0;
        while ($isunknown({pixel_out, ifmap_fwd, filter_fwd}) && wait_cnt < 10) begin
            @(negedge clk);
            wait_cnt++;
        end
        reset_cleared = (wait_cnt < 10);
        if (!reset_cleared) begin
            $display("timeout: outputs still unknown after reset release");
            $display("Something failed");
        end else begin
            reset_test();
            weight_hold_test();
            forwarding_test();
            accumulation_test();
            range_test();
            freeze_test();
            errors += dut.u_assertions.fail_count;     // bound checker failures
            $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
            if (errors == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
        end
        $finish;
    end

    // run limit, far beyond the few hundred cycles needed
    initial begin
        #200000;
        $display("timeout: simulation did not finish within its cycle limit");
        $display("Something failed");
        $finish;
    end

endmodule : conv_column_tb

`default_nettype wire

// ==== list.f ====
source/conv_pkg.sv
source/pe_lane_if.sv
source/weight_feeder.sv
source/pe_unit.sv
source/psum_compressor.sv
source/conv_column.sv
verif/conv_column_assertions.sv
verif/conv_column_tb.sv
